// ==== include/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define DATA_W       32
`define REG_ADDR_W   5
`define IMM_W        16
`define INST_INDEX_W 26  // j-type target index
`define LINK_REG     31
`define PC_STEP      4   // bytes per instruction

`endif

// ==== design/isa_pkg.sv ====
`include "mips_params.svh"

package isa_pkg;

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00, op_regimm = 6'h01, op_j = 6'h02, op_jal = 6'h03,
		op_beq = 6'h04, op_bne = 6'h05, op_blez = 6'h06, op_bgtz = 6'h07,
		op_addi = 6'h08, op_addiu = 6'h09, op_slti = 6'h0a, op_sltiu = 6'h0b,
		op_andi = 6'h0c, op_ori = 6'h0d, op_xori = 6'h0e, op_lui = 6'h0f,
		op_lw = 6'h23, op_sw = 6'h2b
	} opcode_e;

	// SPECIAL function code, inst[5:0]
	typedef enum logic [5:0] {
		fn_sll = 6'h00, fn_srl = 6'h02, fn_sra = 6'h03, fn_sllv = 6'h04,
		fn_srlv = 6'h06, fn_srav = 6'h07, fn_jr = 6'h08, fn_jalr = 6'h09,
		fn_movz = 6'h0a, fn_movn = 6'h0b, fn_mfhi = 6'h10, fn_mthi = 6'h11,
		fn_mflo = 6'h12, fn_mtlo = 6'h13, fn_add = 6'h20, fn_addu = 6'h21,
		fn_sub = 6'h22, fn_subu = 6'h23, fn_and = 6'h24, fn_or = 6'h25,
		fn_xor = 6'h26, fn_nor = 6'h27, fn_slt = 6'h2a, fn_sltu = 6'h2b
	} funct_e;

	// REGIMM rt field
	typedef enum logic [4:0] {
		ri_bltz = 5'h00, ri_bgez = 5'h01, ri_bltzal = 5'h10, ri_bgezal = 5'h11
	} regimm_e;

	typedef logic [`IMM_W-1:0] imm16_t;
	typedef logic [4:0]        shamt_t;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

	// operation handed to execute
	typedef enum logic [7:0] {
		alu_nop = 8'h00, alu_and = 8'h24, alu_or = 8'h25, alu_xor = 8'h26,
		alu_nor = 8'h27, alu_sll = 8'h7c, alu_srl = 8'h02, alu_sra = 8'h03,
		alu_movz = 8'h0a, alu_movn = 8'h0b, alu_mfhi = 8'h10, alu_mthi = 8'h11,
		alu_mflo = 8'h12, alu_mtlo = 8'h13, alu_slt = 8'h2a, alu_sltu = 8'h2b,
		alu_add = 8'h20, alu_addu = 8'h21, alu_sub = 8'h22, alu_subu = 8'h23,
		alu_addi = 8'h55, alu_addiu = 8'h56, alu_j = 8'h4f, alu_jal = 8'h50,
		alu_jalr = 8'h09, alu_jr = 8'h08, alu_beq = 8'h51, alu_bgez = 8'h41,
		alu_bgezal = 8'h4b, alu_bgtz = 8'h54, alu_blez = 8'h53, alu_bltz = 8'h40,
		alu_bltzal = 8'h4a, alu_bne = 8'h52, alu_lw = 8'he3, alu_sw = 8'heb
	} aluop_e;

	// result class
	typedef enum logic [2:0] {
		sel_nop = 3'b000, sel_logic = 3'b001, sel_shift = 3'b010, sel_move = 3'b011,
		sel_arith = 3'b100, sel_jump = 3'b110, sel_load_store = 3'b111
	} alusel_e;

	// operand test done in decode
	typedef enum logic [3:0] {
		br_none, br_jump, br_jump_reg, br_eq, br_ne, br_gtz,
		br_lez, br_gez, br_ltz, br_movn, br_movz
	} branch_e;

endpackage

// ==== design/insn_decoder.sv ====
`include "mips_params.svh"

module insn_decoder (
	input  logic [`DATA_W-1:0]     inst_i,
	output logic                   reg1_read_o,
	output logic                   reg2_read_o,
	output logic [`REG_ADDR_W-1:0] reg1_addr_o,
	output logic [`REG_ADDR_W-1:0] reg2_addr_o,
	output logic [`REG_ADDR_W-1:0] wd_o,
	output logic [`DATA_W-1:0]     imm_o,
	output pipe_pkg::aluop_e       aluop_o,
	output pipe_pkg::alusel_e      alusel_o,
	output logic                   wreg_o,
	output logic                   link_o,
	output logic                   invalid_o,
	output pipe_pkg::branch_e      branch_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e                op;
	funct_e                 fn;
	regimm_e                ri;
	imm16_t                 imm16;
	shamt_t                 shamt;
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`DATA_W-1:0]     imm_sext;
	logic                   valid;

	assign op = opcode_e'(inst_i[31:26]);
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign fn = funct_e'(inst_i[5:0]);
	assign ri = regimm_e'(rt);
	assign imm16 = inst_i[`IMM_W-1:0];
	assign imm_sext = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};

	assign reg1_addr_o = rs;
	assign reg2_addr_o = rt;
	assign invalid_o = !valid;

	// operation code and validity
	always_comb begin
		valid = 1'b1;
		aluop_o = alu_nop;
		case (op)
			op_special: begin
				case (fn)
					fn_and: aluop_o = alu_and;
					fn_or: aluop_o = alu_or;
					fn_xor: aluop_o = alu_xor;
					fn_nor: aluop_o = alu_nor;
					fn_sll, fn_sllv: aluop_o = alu_sll;
					fn_srl, fn_srlv: aluop_o = alu_srl;
					fn_sra, fn_srav: aluop_o = alu_sra;
					fn_add: aluop_o = alu_add;
					fn_addu: aluop_o = alu_addu;
					fn_sub: aluop_o = alu_sub;
					fn_subu: aluop_o = alu_subu;
					fn_slt: aluop_o = alu_slt;
					fn_sltu: aluop_o = alu_sltu;
					fn_mfhi: aluop_o = alu_mfhi;
					fn_mflo: aluop_o = alu_mflo;
					fn_mthi: aluop_o = alu_mthi;
					fn_mtlo: aluop_o = alu_mtlo;
					fn_movn: aluop_o = alu_movn;
					fn_movz: aluop_o = alu_movz;
					fn_jr: aluop_o = alu_jr;
					fn_jalr: aluop_o = alu_jalr;
					default: valid = 1'b0;
				endcase
			end
			op_regimm: begin
				case (ri)
					ri_bltz: aluop_o = alu_bltz;
					ri_bgez: aluop_o = alu_bgez;
					ri_bltzal: aluop_o = alu_bltzal;
					ri_bgezal: aluop_o = alu_bgezal;
					default: valid = 1'b0;
				endcase
			end
			op_andi: aluop_o = alu_and;
			op_ori, op_lui: aluop_o = alu_or;  // lui is an or with rs
			op_xori: aluop_o = alu_xor;
			op_addi: aluop_o = alu_addi;
			op_addiu: aluop_o = alu_addiu;
			op_slti: aluop_o = alu_slt;
			op_sltiu: aluop_o = alu_sltu;
			op_lw: aluop_o = alu_lw;
			op_sw: aluop_o = alu_sw;
			op_j: aluop_o = alu_j;
			op_jal: aluop_o = alu_jal;
			op_beq: aluop_o = alu_beq;
			op_bne: aluop_o = alu_bne;
			op_blez: aluop_o = alu_blez;
			op_bgtz: aluop_o = alu_bgtz;
			default: valid = 1'b0;
		endcase
	end

	always_comb begin
		alusel_o = sel_nop;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		wd_o = rt;  // i-type writes rt
		wreg_o = 1'b0;
		imm_o = '0;
		branch_o = br_none;
		link_o = 1'b0;
		case (op)
			op_special: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				wd_o = rd;
				wreg_o = 1'b1;
				case (fn)
					fn_and, fn_or, fn_xor, fn_nor: alusel_o = sel_logic;
					fn_sllv, fn_srlv, fn_srav: alusel_o = sel_shift;
					fn_sll, fn_srl, fn_sra: begin
						alusel_o = sel_shift;
						reg1_read_o = 1'b0;  // shamt rides in operand 1
						imm_o = {{(`DATA_W-$bits(shamt)){1'b0}}, shamt};
					end
					fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu: alusel_o = sel_arith;
					fn_mfhi, fn_mflo: begin
						alusel_o = sel_move;
						reg1_read_o = 1'b0;
						reg2_read_o = 1'b0;
					end
					fn_mthi, fn_mtlo: begin
						reg2_read_o = 1'b0;
						wreg_o = 1'b0;
					end
					fn_movn, fn_movz: begin
						alusel_o = sel_move;
						wreg_o = 1'b0;  // settled on operand 2
						branch_o = (fn == fn_movn) ? br_movn : br_movz;
					end
					fn_jr, fn_jalr: begin
						alusel_o = sel_jump;
						reg2_read_o = 1'b0;
						wreg_o = 1'b0;
						link_o = (fn == fn_jalr);  // jalr links to rd
						branch_o = br_jump_reg;
					end
					default: ;
				endcase
			end
			op_andi, op_ori, op_xori, op_lui: begin
				alusel_o = sel_logic;
				reg1_read_o = 1'b1;
				wreg_o = 1'b1;
				imm_o = (op == op_lui) ? {imm16, {(`DATA_W-`IMM_W){1'b0}}}
					: {{(`DATA_W-`IMM_W){1'b0}}, imm16};
			end
			op_addi, op_addiu, op_slti, op_sltiu: begin
				alusel_o = sel_arith;
				reg1_read_o = 1'b1;
				wreg_o = 1'b1;
				imm_o = imm_sext;
			end
			op_lw, op_sw: begin
				alusel_o = sel_load_store;
				reg1_read_o = 1'b1;
				reg2_read_o = (op == op_sw);  // store data
				wreg_o = (op == op_lw);
				imm_o = imm_sext;
			end
			op_regimm, op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz: begin
				alusel_o = sel_jump;
				wd_o = `REG_ADDR_W'(`LINK_REG);
				imm_o = imm_sext;  // branch offset
				reg1_read_o = (op != op_j) && (op != op_jal);
				reg2_read_o = (op == op_beq) || (op == op_bne);
				case (op)
					op_j: branch_o = br_jump;
					op_jal: begin
						branch_o = br_jump;
						link_o = 1'b1;
					end
					op_beq: branch_o = br_eq;
					op_bne: branch_o = br_ne;
					op_blez: branch_o = br_lez;
					op_bgtz: branch_o = br_gtz;
					default: begin
						branch_o = (ri == ri_bgez || ri == ri_bgezal) ? br_gez : br_ltz;
						link_o = (ri == ri_bgezal) || (ri == ri_bltzal);
					end
				endcase
			end
			default: ;
		endcase
		// unknown encodings go out as a harmless nop
		if (!valid) begin
			alusel_o = sel_nop;
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			wreg_o = 1'b0;
			link_o = 1'b0;
			branch_o = br_none;
		end
	end

endmodule

// ==== design/operand_forward.sv ====
`include "mips_params.svh"

module operand_forward (
	input  logic                   read_i,
	input  logic [`REG_ADDR_W-1:0] addr_i,
	input  logic [`DATA_W-1:0]     imm_i,
	input  logic [`DATA_W-1:0]     rf_data_i,
	input  pipe_pkg::aluop_e       ex_aluop_i,
	input  logic                   ex_wreg_i,
	input  logic [`REG_ADDR_W-1:0] ex_wd_i,
	input  logic [`DATA_W-1:0]     ex_wdata_i,
	input  logic                   mem_wreg_i,
	input  logic [`REG_ADDR_W-1:0] mem_wd_i,
	input  logic [`DATA_W-1:0]     mem_wdata_i,
	output logic [`DATA_W-1:0]     operand_o,
	output logic                   stall_req_o
);
	import pipe_pkg::*;

	logic ex_hit;
	logic mem_hit;

	assign ex_hit = ex_wreg_i && (ex_wd_i == addr_i);
	assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

	// load data not ready until mem
	assign stall_req_o = read_i && (ex_aluop_i == alu_lw) && (ex_wd_i == addr_i);

	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_wdata_i;  // youngest write wins
		else if (mem_hit)
			operand_o = mem_wdata_i;
		else
			operand_o = rf_data_i;
	end

endmodule

// ==== design/issue_unit.sv ====
`include "mips_params.svh"

module issue_unit (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic [`DATA_W-1:0]     pc_i,
	input  logic [`DATA_W-1:0]     inst_i,
	input  logic [`DATA_W-1:0]     imm_i,
	input  logic [`DATA_W-1:0]     operand1_i,
	input  logic [`DATA_W-1:0]     operand2_i,
	input  pipe_pkg::aluop_e       aluop_i,
	input  pipe_pkg::alusel_e      alusel_i,
	input  logic [`REG_ADDR_W-1:0] wd_i,
	input  logic                   wreg_i,
	input  logic                   link_i,
	input  logic                   invalid_i,
	input  logic                   in_delayslot_i,
	input  logic                   stall1_i,
	input  logic                   stall2_i,
	input  pipe_pkg::branch_e      branch_i,
	output logic                   stall_o,
	output logic                   branch_flag_o,
	output logic                   next_in_delayslot_o,
	output logic [`DATA_W-1:0]     branch_target_o,
	output pipe_pkg::aluop_e       ex_aluop_o,
	output pipe_pkg::alusel_e      ex_alusel_o,
	output logic [`DATA_W-1:0]     ex_reg1_o,
	output logic [`DATA_W-1:0]     ex_reg2_o,
	output logic [`DATA_W-1:0]     ex_link_addr_o,
	output logic [`DATA_W-1:0]     ex_inst_o,
	output logic [`REG_ADDR_W-1:0] ex_wd_o,
	output logic                   ex_wreg_o,
	output logic                   ex_invalid_o,
	output logic                   ex_in_delayslot_o
);
	import pipe_pkg::*;

	logic [`DATA_W-1:0] pc_next;
	logic [`DATA_W-1:0] link_addr;
	logic               op1_neg;
	logic               op1_zero;
	logic               taken;
	logic               wreg;

	assign pc_next = pc_i + `PC_STEP;
	assign link_addr = pc_next + `PC_STEP;  // skip the delay slot
	assign op1_neg = operand1_i[`DATA_W-1];
	assign op1_zero = (operand1_i == '0);

	always_comb begin
		case (branch_i)
			br_jump, br_jump_reg: taken = 1'b1;
			br_eq: taken = (operand1_i == operand2_i);
			br_ne: taken = (operand1_i != operand2_i);
			br_gtz: taken = !op1_neg && !op1_zero;
			br_lez: taken = op1_neg || op1_zero;
			br_gez: taken = !op1_neg;
			br_ltz: taken = op1_neg;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (branch_i)
			br_jump: branch_target_o = {pc_next[`DATA_W-1:`INST_INDEX_W+2],
				inst_i[`INST_INDEX_W-1:0], 2'b00};
			br_jump_reg: branch_target_o = operand1_i;
			default: branch_target_o = pc_next + {imm_i[`DATA_W-3:0], 2'b00};
		endcase
	end

	// conditional moves write only when the test on rt passes
	always_comb begin
		case (branch_i)
			br_movn: wreg = (operand2_i != '0);
			br_movz: wreg = (operand2_i == '0);
			default: wreg = wreg_i || link_i;
		endcase
	end

	assign stall_o = stall1_i || stall2_i;
	assign branch_flag_o = taken && !stall_o;
	assign next_in_delayslot_o = !(branch_i inside {br_none, br_movn, br_movz});

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_aluop_o <= alu_nop;
			ex_alusel_o <= sel_nop;
			ex_wreg_o <= 1'b0;
			ex_invalid_o <= 1'b0;
			ex_in_delayslot_o <= 1'b0;
			ex_wd_o <= '0;
			ex_reg1_o <= '0;
			ex_reg2_o <= '0;
			ex_link_addr_o <= '0;
			ex_inst_o <= '0;
		end else begin
			ex_wd_o <= wd_i;
			ex_reg1_o <= operand1_i;
			ex_reg2_o <= operand2_i;
			ex_link_addr_o <= link_i ? link_addr : '0;
			ex_inst_o <= inst_i;
			if (stall_o) begin
				// bubble
				ex_aluop_o <= alu_nop;
				ex_alusel_o <= sel_nop;
				ex_wreg_o <= 1'b0;
				ex_invalid_o <= 1'b0;
				ex_in_delayslot_o <= 1'b0;
			end else begin
				ex_aluop_o <= aluop_i;
				ex_alusel_o <= alusel_i;
				ex_wreg_o <= wreg;
				ex_invalid_o <= invalid_i;
				ex_in_delayslot_o <= in_delayslot_i;
			end
		end
	end

endmodule

// ==== design/id_stage.sv ====
`include "mips_params.svh"

module id_stage (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic [`DATA_W-1:0]     pc_i,
	input  logic [`DATA_W-1:0]     inst_i,
	input  logic                   in_delayslot_i,
	input  logic [`DATA_W-1:0]     reg1_data_i,
	input  logic [`DATA_W-1:0]     reg2_data_i,
	input  pipe_pkg::aluop_e       ex_aluop_i,
	input  logic                   ex_wreg_i,
	input  logic [`REG_ADDR_W-1:0] ex_wd_i,
	input  logic [`DATA_W-1:0]     ex_wdata_i,
	input  logic                   mem_wreg_i,
	input  logic [`REG_ADDR_W-1:0] mem_wd_i,
	input  logic [`DATA_W-1:0]     mem_wdata_i,
	output logic                   reg1_read_o,
	output logic                   reg2_read_o,
	output logic [`REG_ADDR_W-1:0] reg1_addr_o,
	output logic [`REG_ADDR_W-1:0] reg2_addr_o,
	output logic                   stall_o,
	output logic                   branch_flag_o,
	output logic [`DATA_W-1:0]     branch_target_o,
	output logic                   next_in_delayslot_o,
	output pipe_pkg::aluop_e       ex_aluop_o,
	output pipe_pkg::alusel_e      ex_alusel_o,
	output logic [`DATA_W-1:0]     ex_reg1_o,
	output logic [`DATA_W-1:0]     ex_reg2_o,
	output logic [`DATA_W-1:0]     ex_link_addr_o,
	output logic [`DATA_W-1:0]     ex_inst_o,
	output logic [`REG_ADDR_W-1:0] ex_wd_o,
	output logic                   ex_wreg_o,
	output logic                   ex_invalid_o,
	output logic                   ex_in_delayslot_o
);
	import pipe_pkg::*;

	aluop_e                 aluop;
	alusel_e                alusel;
	branch_e                branch;
	logic [`DATA_W-1:0]     imm;
	logic [`DATA_W-1:0]     operand1;
	logic [`DATA_W-1:0]     operand2;
	logic [`REG_ADDR_W-1:0] wd;
	logic                   wreg;
	logic                   link;
	logic                   invalid;
	logic                   stall1;
	logic                   stall2;

	insn_decoder decoder_i (
		.inst_i(inst_i), .reg1_read_o(reg1_read_o), .reg2_read_o(reg2_read_o),
		.reg1_addr_o(reg1_addr_o), .reg2_addr_o(reg2_addr_o), .wd_o(wd), .imm_o(imm),
		.aluop_o(aluop), .alusel_o(alusel), .wreg_o(wreg), .link_o(link),
		.invalid_o(invalid), .branch_o(branch)
	);

	// rs side
	operand_forward fwd1_i (
		.read_i(reg1_read_o), .addr_i(reg1_addr_o), .imm_i(imm), .rf_data_i(reg1_data_i),
		.ex_aluop_i(ex_aluop_i), .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i),
		.ex_wdata_i(ex_wdata_i), .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i),
		.mem_wdata_i(mem_wdata_i), .operand_o(operand1), .stall_req_o(stall1)
	);

	// rt side
	operand_forward fwd2_i (
		.read_i(reg2_read_o), .addr_i(reg2_addr_o), .imm_i(imm), .rf_data_i(reg2_data_i),
		.ex_aluop_i(ex_aluop_i), .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i),
		.ex_wdata_i(ex_wdata_i), .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i),
		.mem_wdata_i(mem_wdata_i), .operand_o(operand2), .stall_req_o(stall2)
	);

	issue_unit issue_i (
		.clk(clk), .arst_n_i(arst_n_i), .pc_i(pc_i), .inst_i(inst_i), .imm_i(imm),
		.operand1_i(operand1), .operand2_i(operand2), .aluop_i(aluop), .alusel_i(alusel),
		.wd_i(wd), .wreg_i(wreg), .link_i(link), .invalid_i(invalid),
		.in_delayslot_i(in_delayslot_i), .stall1_i(stall1), .stall2_i(stall2),
		.branch_i(branch), .stall_o(stall_o), .branch_flag_o(branch_flag_o),
		.next_in_delayslot_o(next_in_delayslot_o), .branch_target_o(branch_target_o),
		.ex_aluop_o(ex_aluop_o), .ex_alusel_o(ex_alusel_o), .ex_reg1_o(ex_reg1_o),
		.ex_reg2_o(ex_reg2_o), .ex_link_addr_o(ex_link_addr_o), .ex_inst_o(ex_inst_o),
		.ex_wd_o(ex_wd_o), .ex_wreg_o(ex_wreg_o), .ex_invalid_o(ex_invalid_o),
		.ex_in_delayslot_o(ex_in_delayslot_o)
	);

endmodule

// ==== sim/id_stage_assert.sv ====
`include "mips_params.svh"

module id_stage_assert (
	input logic                   clk,
	input logic                   arst_n_i,
	input logic                   stall_o,
	input logic                   branch_flag_o,
	input pipe_pkg::aluop_e       ex_aluop_o,
	input pipe_pkg::alusel_e      ex_alusel_o,
	input logic [`DATA_W-1:0]     ex_reg1_o,
	input logic [`DATA_W-1:0]     ex_reg2_o,
	input logic [`DATA_W-1:0]     ex_link_addr_o,
	input logic [`DATA_W-1:0]     ex_inst_o,
	input logic [`REG_ADDR_W-1:0] ex_wd_o,
	input logic                   ex_wreg_o,
	input logic                   ex_invalid_o,
	input logic                   ex_in_delayslot_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import pipe_pkg::*;

	int fail_cnt = 0;

	// stalled instruction becomes a bubble
	bubble_after_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		stall_o |=> (ex_aluop_o == alu_nop) && (ex_alusel_o == sel_nop) && !ex_wreg_o
			&& !ex_invalid_o)
	else begin
		$error("stall was not followed by a bubble");
		fail_cnt++;
	end

	no_branch_in_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		stall_o |-> !branch_flag_o)
	else begin
		$error("branch flag raised during a stall");
		fail_cnt++;
	end

	reset_values: assert property (@(posedge clk)
		!arst_n_i |-> (ex_aluop_o == alu_nop) && (ex_alusel_o == sel_nop) && !ex_wreg_o
			&& !ex_invalid_o && !ex_in_delayslot_o && (ex_wd_o == '0) && (ex_reg1_o == '0)
			&& (ex_reg2_o == '0) && (ex_link_addr_o == '0) && (ex_inst_o == '0))
	else begin
		$error("ID/EX register not cleared in reset");
		fail_cnt++;
	end

	invalid_never_writes: assert property (@(posedge clk) disable iff (!arst_n_i)
		ex_invalid_o |-> !ex_wreg_o)
	else begin
		$error("invalid instruction carries a write enable");
		fail_cnt++;
	end

endmodule

bind id_stage id_stage_assert assert_i (.*);

// ==== sim/id_stage_tb.sv ====
`include "mips_params.svh"

module id_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int WAIT_MAX = 100;  // ns allowed per edge

	logic clk, arst_n_i, in_delayslot_i, ex_wreg_i, mem_wreg_i;
	logic [`DATA_W-1:0] pc_i, inst_i, reg1_data_i, reg2_data_i, ex_wdata_i, mem_wdata_i;
	logic [`REG_ADDR_W-1:0] ex_wd_i, mem_wd_i;
	aluop_e ex_aluop_i;
	logic reg1_read_o, reg2_read_o, stall_o, branch_flag_o, next_in_delayslot_o;
	logic ex_wreg_o, ex_invalid_o, ex_in_delayslot_o;
	logic [`REG_ADDR_W-1:0] reg1_addr_o, reg2_addr_o, ex_wd_o;
	logic [`DATA_W-1:0] branch_target_o, ex_reg1_o, ex_reg2_o, ex_link_addr_o, ex_inst_o;
	aluop_e ex_aluop_o;
	alusel_e ex_alusel_o;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_start = 0;
	int fall_cnt = 0;
	logic [31:0] lcg_state = 32'hbd3c;
	logic [`REG_ADDR_W-1:0] rs, rt, rd, sa;

	id_stage id_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) fall_cnt++;

	// register file model, zero for r0
	function automatic logic [31:0] rf_pattern(logic [4:0] a);
		return (a == '0) ? '0 : {3'b101, a, 3'b010, a, ~a, 3'b000, a, 3'b110};
	endfunction

	assign reg1_data_i = rf_pattern(reg1_addr_o);
	assign reg2_data_i = rf_pattern(reg2_addr_o);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] enc_r(logic [4:0] s, logic [4:0] t, logic [4:0] d,
			logic [4:0] shamt, funct_e fn);
		return {6'h00, s, t, d, shamt, fn};
	endfunction

	function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] s, logic [4:0] t,
			logic [15:0] imm);
		return {op, s, t, imm};
	endfunction

	task automatic wait_fall();
		int start;
		int n;
		start = fall_cnt;
		n = 0;
		while (fall_cnt == start && n < WAIT_MAX) begin
			#1;
			n++;
		end
		if (fall_cnt == start) begin
			$display("timeout waiting for a falling clock edge");
			$display("RESULT: FAIL");
			$finish;
		end
	endtask

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic end_test(string name);
		tests_run++;
		if (errors != test_err_start) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_err_start);
		end else begin
			$display("test %s: ok", name);
		end
		test_err_start = errors;
	endtask

	task automatic clear_fwd();
		ex_aluop_i = alu_nop;
		ex_wreg_i = 1'b0;
		ex_wd_i = '0;
		ex_wdata_i = '0;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
	endtask

	task automatic check_reset_state();
		check("ex_wreg_o", 32'(ex_wreg_o), 32'h0);
		check("ex_aluop_o", 32'(ex_aluop_o), 32'(alu_nop));
		check("ex_reg1_o", ex_reg1_o, 32'h0);
		check("ex_reg2_o", ex_reg2_o, 32'h0);
		check("ex_link_addr_o", ex_link_addr_o, 32'h0);
	endtask

	task automatic check_ex(aluop_e op, alusel_e sel, logic [4:0] wd, logic wreg,
			logic [31:0] r1, logic [31:0] r2);
		check("ex_aluop_o", 32'(ex_aluop_o), 32'(op));
		check("ex_alusel_o", 32'(ex_alusel_o), 32'(sel));
		check("ex_wd_o", 32'(ex_wd_o), 32'(wd));
		check("ex_wreg_o", 32'(ex_wreg_o), 32'(wreg));
		check("ex_reg1_o", ex_reg1_o, r1);
		check("ex_reg2_o", ex_reg2_o, r2);
	endtask

	task automatic decode_case(logic [31:0] inst, aluop_e op, alusel_e sel, logic [4:0] wd,
			logic wreg, logic [31:0] r1, logic [31:0] r2);
		inst_i = inst;
		wait_fall();
		check_ex(op, sel, wd, wreg, r1, r2);
		check("ex_inst_o", ex_inst_o, inst);
		check("ex_in_delayslot_o", 32'(ex_in_delayslot_o), 32'(in_delayslot_i));
		// inst_i still held here
		check("reg1_addr_o", 32'(reg1_addr_o), 32'(inst[25:21]));
		check("reg2_addr_o", 32'(reg2_addr_o), 32'(inst[20:16]));
		check("next_in_delayslot_o", 32'(next_in_delayslot_o), 32'h0);
	endtask

	// rs value comes in from execute, rt value from memory
	task automatic branch_case(logic [31:0] inst, logic [31:0] op1, logic [31:0] op2,
			logic taken, logic [31:0] target, logic link);
		ex_wreg_i = 1'b1;
		ex_wd_i = inst[25:21];
		ex_wdata_i = op1;
		mem_wreg_i = 1'b1;
		mem_wd_i = inst[20:16];
		mem_wdata_i = op2;
		inst_i = inst;
		#5;
		check("branch_flag_o", 32'(branch_flag_o), 32'(taken));
		check("branch_target_o", branch_target_o, target);
		check("next_in_delayslot_o", 32'(next_in_delayslot_o), 32'h1);
		// j and jal name no register, only beq and bne compare rt
		check("reg1_read_o", 32'(reg1_read_o),
			32'(inst[31:26] != op_j && inst[31:26] != op_jal));
		check("reg2_read_o", 32'(reg2_read_o),
			32'(inst[31:26] == op_beq || inst[31:26] == op_bne));
		wait_fall();
		check("ex_wreg_o", 32'(ex_wreg_o), 32'(link));
		if (link) begin
			check("ex_link_addr_o", ex_link_addr_o, pc_i + 32'd8);
			check("ex_wd_o", 32'(ex_wd_o), 32'(`LINK_REG));
		end
	endtask

	task automatic cmov_case(funct_e fn, logic [31:0] rt_val, logic wreg);
		ex_wreg_i = 1'b0;
		mem_wreg_i = 1'b1;
		mem_wd_i = rt;
		mem_wdata_i = rt_val;
		inst_i = enc_r(rs, rt, rd, 5'd0, fn);
		wait_fall();
		check("ex_wreg_o", 32'(ex_wreg_o), 32'(wreg));
		check("ex_wd_o", 32'(ex_wd_o), 32'(rd));
		check("ex_reg2_o", ex_reg2_o, rt_val);
		check("next_in_delayslot_o", 32'(next_in_delayslot_o), 32'h0);
	endtask

	initial begin
		logic [31:0] r, dx, dm, v, bt, jt, tgt, pn;
		logic [15:0] imm;
		logic [31:0] sext;
		int total_err;

		arst_n_i = 1'b1;
		pc_i = '0;
		inst_i = '0;
		in_delayslot_i = 1'b0;
		clear_fwd();
		#1 arst_n_i = 1'b0;

		// reset and invalid opcode
		repeat (5) wait_fall();
		check_reset_state();
		arst_n_i = 1'b1;
		check_reset_state();
		inst_i = {6'h3f, 26'h0};
		wait_fall();
		check("ex_invalid_o", 32'(ex_invalid_o), 32'h1);
		check("ex_wreg_o", 32'(ex_wreg_o), 32'h0);
		check("ex_aluop_o", 32'(ex_aluop_o), 32'(alu_nop));
		end_test("reset");

		for (int k = 0; k < 3; k++) begin
			r = lcg_next();
			rs = r[4:0];
			rt = r[9:5];
			rd = r[14:10];
			sa = r[20:16];
			imm = r[31:16];
			sext = {{16{imm[15]}}, imm};
			in_delayslot_i = r[15];
			decode_case(enc_i(op_ori, rs, rt, imm), alu_or, sel_logic, rt, 1'b1,
				rf_pattern(rs), {16'h0, imm});
			decode_case(enc_i(op_lui, rs, rt, imm), alu_or, sel_logic, rt, 1'b1,
				rf_pattern(rs), {imm, 16'h0});
			decode_case(enc_i(op_addiu, rs, rt, imm), alu_addiu, sel_arith, rt, 1'b1,
				rf_pattern(rs), sext);
			decode_case(enc_i(op_slti, rs, rt, imm), alu_slt, sel_arith, rt, 1'b1,
				rf_pattern(rs), sext);
			decode_case(enc_r(rs, rt, rd, sa, fn_sll), alu_sll, sel_shift, rd, 1'b1,
				{27'h0, sa}, rf_pattern(rt));
			decode_case(enc_r(rs, rt, rd, 5'd0, fn_addu), alu_addu, sel_arith, rd, 1'b1,
				rf_pattern(rs), rf_pattern(rt));
			decode_case(enc_r(rs, rt, rd, 5'd0, fn_slt), alu_slt, sel_arith, rd, 1'b1,
				rf_pattern(rs), rf_pattern(rt));
			decode_case(enc_i(op_sw, rs, rt, imm), alu_sw, sel_load_store, rt, 1'b0,
				rf_pattern(rs), rf_pattern(rt));
		end
		end_test("alu_decode");

		// rs odd, rt and the spare register differ from it
		r = lcg_next();
		rs = {r[3:0], 1'b1};
		rt = rs ^ 5'h2;
		rd = r[8:4];
		dx = lcg_next();
		dm = lcg_next();
		ex_wreg_i = 1'b1;
		ex_wd_i = rs;
		ex_wdata_i = dx;
		mem_wreg_i = 1'b1;
		mem_wd_i = rs;
		mem_wdata_i = dm;
		decode_case(enc_r(rs, rt, rd, 5'd0, fn_addu), alu_addu, sel_arith, rd, 1'b1,
			dx, rf_pattern(rt));
		ex_wd_i = rs ^ 5'h4;
		decode_case(enc_r(rs, rt, rd, 5'd0, fn_addu), alu_addu, sel_arith, rd, 1'b1,
			dm, rf_pattern(rt));
		mem_wd_i = rs ^ 5'h4;
		decode_case(enc_r(rs, rt, rd, 5'd0, fn_addu), alu_addu, sel_arith, rd, 1'b1,
			rf_pattern(rs), rf_pattern(rt));
		ex_wd_i = rt;
		mem_wd_i = rs;
		decode_case(enc_r(rs, rt, rd, 5'd0, fn_addu), alu_addu, sel_arith, rd, 1'b1,
			dm, dx);
		end_test("forwarding");

		// load in execute feeding rs, then rt of a branch
		clear_fwd();
		ex_aluop_i = alu_lw;
		ex_wreg_i = 1'b1;
		ex_wd_i = rs;
		inst_i = enc_r(rs, rt, rd, 5'd0, fn_addu);
		#5;
		check("stall_o", 32'(stall_o), 32'h1);
		wait_fall();
		check("ex_aluop_o", 32'(ex_aluop_o), 32'(alu_nop));
		check("ex_alusel_o", 32'(ex_alusel_o), 32'(sel_nop));
		check("ex_wreg_o", 32'(ex_wreg_o), 32'h0);
		check("ex_invalid_o", 32'(ex_invalid_o), 32'h0);
		ex_wd_i = rt;
		ex_wdata_i = rf_pattern(rs);  // operands equal, the beq would be taken
		inst_i = enc_i(op_beq, rs, rt, 16'h0010);
		#5;
		check("stall_o", 32'(stall_o), 32'h1);
		check("branch_flag_o", 32'(branch_flag_o), 32'h0);
		wait_fall();
		check("ex_aluop_o", 32'(ex_aluop_o), 32'(alu_nop));
		clear_fwd();
		#5;
		check("stall_o", 32'(stall_o), 32'h0);
		wait_fall();
		end_test("load_use_stall");

		r = lcg_next();
		pc_i = {4'h3, r[27:2], 2'b00};
		r = lcg_next();
		rs = {1'b0, r[19:16]} | 5'h1;
		rt = rs | 5'h10;
		imm = r[15:0];
		pn = pc_i + 32'd4;
		bt = pn + {{14{imm[15]}}, imm, 2'b00};
		jt = {pn[31:28], r[25:0], 2'b00};
		v = lcg_next();
		tgt = lcg_next() & 32'hffff_fffc;
		branch_case(enc_i(op_beq, rs, rt, imm), v, v, 1'b1, bt, 1'b0);
		branch_case(enc_i(op_beq, rs, rt, imm), v, v + 32'd1, 1'b0, bt, 1'b0);
		branch_case(enc_i(op_bne, rs, rt, imm), v, v ^ 32'h1, 1'b1, bt, 1'b0);
		branch_case(enc_i(op_bne, rs, rt, imm), v, v, 1'b0, bt, 1'b0);
		branch_case(enc_i(op_bgtz, rs, 5'd0, imm), 32'd5, 32'd0, 1'b1, bt, 1'b0);
		branch_case(enc_i(op_bgtz, rs, 5'd0, imm), 32'd0, 32'd0, 1'b0, bt, 1'b0);
		branch_case(enc_i(op_blez, rs, 5'd0, imm), 32'd0, 32'd0, 1'b1, bt, 1'b0);
		branch_case(enc_i(op_blez, rs, 5'd0, imm), 32'd7, 32'd0, 1'b0, bt, 1'b0);
		branch_case(enc_i(op_regimm, rs, ri_bgez, imm), 32'd0, 32'd0, 1'b1, bt, 1'b0);
		branch_case(enc_i(op_regimm, rs, ri_bgez, imm), 32'h8000_0001, 32'd0, 1'b0, bt,
			1'b0);
		branch_case(enc_i(op_regimm, rs, ri_bltz, imm), 32'hffff_fff0, 32'd0, 1'b1, bt,
			1'b0);
		branch_case(enc_i(op_regimm, rs, ri_bltz, imm), 32'd3, 32'd0, 1'b0, bt, 1'b0);
		branch_case({op_j, r[25:0]}, 32'd0, 32'd0, 1'b1, jt, 1'b0);
		branch_case({op_jal, r[25:0]}, 32'd0, 32'd0, 1'b1, jt, 1'b1);
		branch_case(enc_r(rs, 5'd0, 5'd0, 5'd0, fn_jr), tgt, 32'd0, 1'b1, tgt, 1'b0);
		branch_case(enc_i(op_regimm, rs, ri_bgezal, imm), 32'd12, 32'd0, 1'b1, bt, 1'b1);
		clear_fwd();
		end_test("branches");

		r = lcg_next();
		rs = {1'b0, r[3:0]} | 5'h1;
		rt = rs | 5'h10;
		rd = r[8:4];
		cmov_case(fn_movn, r | 32'h1, 1'b1);
		cmov_case(fn_movn, 32'h0, 1'b0);
		cmov_case(fn_movz, 32'h0, 1'b1);
		cmov_case(fn_movz, r | 32'h1, 1'b0);
		clear_fwd();
		end_test("conditional_move");

		wait_fall();
		total_err = errors + id_stage_i.assert_i.fail_cnt;
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, id_stage_i.assert_i.fail_cnt);
		if (total_err == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/insn_decoder.sv
design/operand_forward.sv
design/issue_unit.sv
design/id_stage.sv
sim/id_stage_assert.sv
sim/id_stage_tb.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= id_stage_tb
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir
RUN_ARGS ?= +verilator+error+limit+1000
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
